// File: hdl/stage_defines.svh
// Stage sizing; widths feed stage_pkg, and the bias sits at index STAGE_TAPS so IDX_W must cover it
`ifndef STAGE_DEFINES_SVH
`define STAGE_DEFINES_SVH

// Taps per stage, also the number of samples in one frame
`define STAGE_TAPS      4

// Index over taps 0..3 plus the bias at 4
`define STAGE_IDX_W     3

// LMS step size as an arithmetic right shift
`define STAGE_MU_SHIFT  8

// Datapath widths
`define STAGE_SAMPLE_W  16
`define STAGE_ERR_W     24
`define STAGE_ACC_W     32

`endif

// File: hdl/stage_pkg.sv
// Shared integer types for the LMS stage; all arithmetic is two's complement and wraps
`include "stage_defines.svh"

package stage_pkg;

  // Input sample and coefficient share one width
  typedef logic signed [`STAGE_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`STAGE_SAMPLE_W-1:0] weight_t;

  // Error sample from the downstream comparator
  typedef logic signed [`STAGE_ERR_W-1:0] err_t;

  // Forward-pass accumulator, also the stage output
  typedef logic signed [`STAGE_ACC_W-1:0] acc_t;

  // Frame sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MAC,
    ST_BIAS,
    ST_HOLD,
    ST_WAIT_ERR,
    ST_UPDATE
  } seq_state_t;

endpackage

// File: hdl/sample_stream_if.sv
// Valid/ready stream with a frame-start marker; a beat moves only when vld and rdy are both high
`timescale 1ns/1ps

interface sample_stream_if #(
  parameter type T = logic
);

  T     data;
  logic fst;
  logic vld;
  logic rdy;

  // Producer side
  modport source (output data, output fst, output vld, input rdy);

  // Consumer side, owns rdy
  modport sink (input data, input fst, input vld, output rdy);

endinterface

// File: hdl/coef_bus_if.sv
// Sequencer to coefficient store link; rd_data is combinational and upd_en is a one-cycle strobe
`timescale 1ns/1ps
`include "stage_defines.svh"

interface coef_bus_if import stage_pkg::*;;

  // Read side, index STAGE_TAPS selects the bias
  logic [`STAGE_IDX_W-1:0] rd_idx;
  weight_t                 rd_data;

  // Update write port
  logic                    upd_en;
  logic [`STAGE_IDX_W-1:0] upd_idx;
  weight_t                 upd_data;

  modport seq (output rd_idx, output upd_en, output upd_idx, output upd_data,
               input  rd_data);

  modport store (input  rd_idx, input  upd_en, input  upd_idx, input  upd_data,
                 output rd_data);

endinterface

// File: hdl/frame_buffer.sv
// One frame of DEPTH beats is held until release_frame; rd_idx bits above the array index are ignored
`timescale 1ns/1ps
`include "stage_defines.svh"

module frame_buffer #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  sample_stream_if.sink           in,
  input  logic [`STAGE_IDX_W-1:0] rd_idx,
  output T                        rd_data,
  output logic                    full,
  output logic                    filled,
  input  logic                    release_frame
);

  // Array index width, at least one bit for a single-entry buffer
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  localparam logic [`STAGE_IDX_W-1:0] LAST_SLOT = `STAGE_IDX_W'(DEPTH - 1);

  T                        mem [DEPTH];
  logic [`STAGE_IDX_W-1:0] wr_idx;
  logic [`STAGE_IDX_W-1:0] slot;
  logic                    beat;

  //////////////////////////////////////////////////////////////////////
  // Capture
  //////////////////////////////////////////////////////////////////////

  // No space once a frame is complete
  assign in.rdy = ~full;
  assign beat   = in.vld & in.rdy;

  // A first marker restarts the frame at slot 0
  assign slot = in.fst ? '0 : wr_idx;

  always_ff @(posedge clk) begin
    if (beat) begin
      mem[slot[AW-1:0]] <= in.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx <= '0;
      full   <= 1'b0;
      filled <= 1'b0;
    end else begin
      filled <= 1'b0;
      if (release_frame) begin
        full <= 1'b0;
      end
      if (beat) begin
        if (slot == LAST_SLOT) begin
          wr_idx <= '0;
          full   <= 1'b1;
          filled <= 1'b1;
        end else begin
          wr_idx <= slot + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read
  //////////////////////////////////////////////////////////////////////

  // Valid only while full
  assign rd_data = mem[rd_idx[AW-1:0]];

endmodule

// File: hdl/coef_store.sv
// Taps and bias reset to zero; a sequencer update wins over an external write in the same cycle
`timescale 1ns/1ps
`include "stage_defines.svh"

module coef_store import stage_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  coef_bus_if.store               bus,
  input  logic                    coef_wr_en,
  input  logic [`STAGE_IDX_W-1:0] coef_wr_addr,
  input  weight_t                 coef_wr_data
);

  localparam int TAP_AW = $clog2(`STAGE_TAPS);

  localparam logic [`STAGE_IDX_W-1:0] BIAS_IDX = `STAGE_IDX_W'(`STAGE_TAPS);

  weight_t                 taps [`STAGE_TAPS];
  weight_t                 bias;
  logic                    wr_en;
  logic [`STAGE_IDX_W-1:0] wr_idx;
  weight_t                 wr_data;

  // Zero-cycle read
  assign bus.rd_data = (bus.rd_idx == BIAS_IDX) ? bias : taps[bus.rd_idx[TAP_AW-1:0]];

  // Write arbitration
  always_comb begin
    wr_en = bus.upd_en | coef_wr_en;
    if (bus.upd_en) begin
      wr_idx  = bus.upd_idx;
      wr_data = bus.upd_data;
    end else begin
      wr_idx  = coef_wr_addr;
      wr_data = coef_wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `STAGE_TAPS; i++) begin
        taps[i] <= '0;
      end
      bias <= '0;
    end else if (wr_en) begin
      if (wr_idx == BIAS_IDX) begin
        bias <= wr_data;
      end else if (wr_idx < BIAS_IDX) begin
        taps[wr_idx[TAP_AW-1:0]] <= wr_data;
      end
      // Addresses above the bias are dropped
    end
  end

endmodule

// File: hdl/stage_seq.sv
// Enables are sampled at the y handshake; error must sit in a one-entry buffer before the update
`timescale 1ns/1ps
`include "stage_defines.svh"

module stage_seq import stage_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  coef_bus_if.seq                 coef,
  output logic [`STAGE_IDX_W-1:0] x_rd_idx,
  input  sample_t                 x_rd_data,
  input  logic                    x_full,
  output logic                    x_release,
  input  err_t                    e_rd_data,
  input  logic                    e_full,
  output logic                    e_release,
  output acc_t                    y_data,
  output logic                    y_vld,
  input  logic                    y_rdy,
  input  logic                    tap_update_enable,
  input  logic                    bias_update_enable,
  output logic                    update_done
);

  localparam logic [`STAGE_IDX_W-1:0] LAST_TAP = `STAGE_IDX_W'(`STAGE_TAPS - 1);
  localparam logic [`STAGE_IDX_W-1:0] BIAS_IDX = `STAGE_IDX_W'(`STAGE_TAPS);

  seq_state_t state;

  logic [`STAGE_IDX_W-1:0] idx;
  acc_t                    acc;
  acc_t                    prod;
  logic                    upd_taps;
  logic                    upd_bias;
  logic                    want_upd;
  logic                    hold_done;
  logic                    last_upd;

  // Error times sample, full precision before the shift
  logic signed [`STAGE_ERR_W+`STAGE_SAMPLE_W-1:0] grad;

  weight_t tap_step;
  weight_t bias_step;
  weight_t coef_step;
  logic    step_en;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Same index walks the sample buffer and the coefficients
  assign x_rd_idx    = idx;
  assign coef.rd_idx = idx;

  assign prod = acc_t'(x_rd_data) * acc_t'(coef.rd_data);

  assign grad      = e_rd_data * x_rd_data;
  assign tap_step  = weight_t'(grad >>> `STAGE_MU_SHIFT);
  assign bias_step = weight_t'(e_rd_data >>> `STAGE_MU_SHIFT);

  always_comb begin
    if (idx == BIAS_IDX) begin
      coef_step = bias_step;
      step_en   = upd_bias;
    end else begin
      coef_step = tap_step;
      step_en   = upd_taps;
    end
  end

  // Disabled coefficients are written back as read
  assign coef.upd_en   = (state == ST_UPDATE);
  assign coef.upd_idx  = idx;
  assign coef.upd_data = step_en ? weight_t'(coef.rd_data + coef_step) : coef.rd_data;

  assign y_data = acc;
  assign y_vld  = (state == ST_HOLD);

  //////////////////////////////////////////////////////////////////////
  // Frame release
  //////////////////////////////////////////////////////////////////////

  assign want_upd  = tap_update_enable | bias_update_enable;
  assign hold_done = (state == ST_HOLD) & y_rdy;
  assign last_upd  = (state == ST_UPDATE) & (idx == BIAS_IDX);

  // Without an update the frame goes right after the output handshake
  assign x_release = last_upd | (hold_done & ~want_upd);
  assign e_release = last_upd;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      idx         <= '0;
      upd_taps    <= 1'b0;
      upd_bias    <= 1'b0;
      update_done <= 1'b0;
    end else begin
      update_done <= last_upd;
      case (state)
        // Tap 0 is taken in the same cycle the frame shows up
        ST_IDLE: begin
          if (x_full) begin
            idx   <= idx + 1'b1;
            state <= ST_MAC;
          end
        end
        ST_MAC: begin
          idx <= idx + 1'b1;
          if (idx == LAST_TAP) begin
            state <= ST_BIAS;
          end
        end
        ST_BIAS: begin
          idx   <= '0;
          state <= ST_HOLD;
        end
        ST_HOLD: begin
          if (y_rdy) begin
            upd_taps <= tap_update_enable;
            upd_bias <= bias_update_enable;
            state    <= want_upd ? ST_WAIT_ERR : ST_IDLE;
          end
        end
        ST_WAIT_ERR: begin
          if (e_full) begin
            state <= ST_UPDATE;
          end
        end
        ST_UPDATE: begin
          if (idx == BIAS_IDX) begin
            idx   <= '0;
            state <= ST_IDLE;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Accumulator, held through back-pressure
  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: begin
        if (x_full) begin
          acc <= prod;
        end
      end
      ST_MAC:  acc <= acc + prod;
      ST_BIAS: acc <= acc + acc_t'(coef.rd_data);
      default: ;
    endcase
  end

endmodule

// File: hdl/stage_ctrl.sv
// Single LMS stage, no chaining; frames are 4 samples and each update consumes exactly one error beat
`timescale 1ns/1ps
`include "stage_defines.svh"

module stage_ctrl import stage_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  sample_t                 x_data,
  input  logic                    x_fst,
  input  logic                    x_vld,
  output logic                    x_rdy,
  input  err_t                    e_data,
  input  logic                    e_fst,
  input  logic                    e_vld,
  output logic                    e_rdy,
  output acc_t                    y_data,
  output logic                    y_vld,
  input  logic                    y_rdy,
  input  logic                    tap_update_enable,
  input  logic                    bias_update_enable,
  input  logic                    coef_wr_en,
  input  logic [`STAGE_IDX_W-1:0] coef_wr_addr,
  input  weight_t                 coef_wr_data,
  output logic                    load_finish,
  output logic                    update_done
);

  sample_stream_if #(.T(sample_t)) x_if ();
  sample_stream_if #(.T(err_t))    e_if ();
  coef_bus_if                      coef_if ();

  logic [`STAGE_IDX_W-1:0] x_rd_idx;
  sample_t                 x_rd_data;
  logic                    x_full;
  logic                    x_release;
  err_t                    e_rd_data;
  logic                    e_full;
  logic                    e_release;

  // Port to interface mapping
  assign x_if.data = x_data;
  assign x_if.fst  = x_fst;
  assign x_if.vld  = x_vld;
  assign x_rdy     = x_if.rdy;

  assign e_if.data = e_data;
  assign e_if.fst  = e_fst;
  assign e_if.vld  = e_vld;
  assign e_rdy     = e_if.rdy;

  //////////////////////////////////////////////////////////////////////
  // Buffers
  //////////////////////////////////////////////////////////////////////

  frame_buffer #(.T(sample_t), .DEPTH(`STAGE_TAPS)) u_data_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .in            (x_if.sink),
    .rd_idx        (x_rd_idx),
    .rd_data       (x_rd_data),
    .full          (x_full),
    .filled        (load_finish),
    .release_frame (x_release)
  );

  // Single error entry, always read at slot 0
  frame_buffer #(.T(err_t), .DEPTH(1)) u_err_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .in            (e_if.sink),
    .rd_idx        ('0),
    .rd_data       (e_rd_data),
    .full          (e_full),
    .filled        (),
    .release_frame (e_release)
  );

  //////////////////////////////////////////////////////////////////////
  // Coefficients and sequencer
  //////////////////////////////////////////////////////////////////////

  coef_store u_coef_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (coef_if.store),
    .coef_wr_en   (coef_wr_en),
    .coef_wr_addr (coef_wr_addr),
    .coef_wr_data (coef_wr_data)
  );

  stage_seq u_stage_seq (
    .clk                (clk),
    .rst_n              (rst_n),
    .coef               (coef_if.seq),
    .x_rd_idx           (x_rd_idx),
    .x_rd_data          (x_rd_data),
    .x_full             (x_full),
    .x_release          (x_release),
    .e_rd_data          (e_rd_data),
    .e_full             (e_full),
    .e_release          (e_release),
    .y_data             (y_data),
    .y_vld              (y_vld),
    .y_rdy              (y_rdy),
    .tap_update_enable  (tap_update_enable),
    .bias_update_enable (bias_update_enable),
    .update_done        (update_done)
  );

endmodule

// File: dv/stage_ctrl_tb.sv
// Directed testbench with an LMS model; needs --timing and --assert under Verilator; the run is capped at 20000 cycles
`timescale 1ns/1ps
`include "stage_defines.svh"

module stage_ctrl_tb import stage_pkg::*; ();

  // About 30 cycles per frame over roughly 30 frames, so a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic                    clk;
  logic                    rst_n;
  sample_t                 x_data;
  logic                    x_fst, x_vld, x_rdy;
  err_t                    e_data;
  logic                    e_fst, e_vld, e_rdy;
  acc_t                    y_data;
  logic                    y_vld, y_rdy;
  logic                    tap_update_enable, bias_update_enable;
  logic                    coef_wr_en;
  logic [`STAGE_IDX_W-1:0] coef_wr_addr;
  weight_t                 coef_wr_data;
  logic                    load_finish, update_done;

  int         errors = 0;
  int         checks = 0;
  int         load_cnt = 0;
  int         done_cnt = 0;
  int         seed;
  sample_t    cur_frame [`STAGE_TAPS];
  weight_t    model_taps [`STAGE_TAPS];
  weight_t    model_bias;
  seq_state_t seq_state;

  assign seq_state = i_stage_ctrl.u_stage_seq.state;

  stage_ctrl i_stage_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .x_data             (x_data),
    .x_fst              (x_fst),
    .x_vld              (x_vld),
    .x_rdy              (x_rdy),
    .e_data             (e_data),
    .e_fst              (e_fst),
    .e_vld              (e_vld),
    .e_rdy              (e_rdy),
    .y_data             (y_data),
    .y_vld              (y_vld),
    .y_rdy              (y_rdy),
    .tap_update_enable  (tap_update_enable),
    .bias_update_enable (bias_update_enable),
    .coef_wr_en         (coef_wr_en),
    .coef_wr_addr       (coef_wr_addr),
    .coef_wr_data       (coef_wr_data),
    .load_finish        (load_finish),
    .update_done        (update_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Pulse counters
  always @(posedge clk) begin
    load_cnt <= load_cnt + int'(load_finish);
    done_cnt <= done_cnt + int'(update_done);
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, sequencer in state %s", cycles, seq_state.name());
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Sum of tap times sample plus bias wraps at 32 bits
  function automatic acc_t model_output();
    int sum;
    sum = int'(model_bias);
    for (int i = 0; i < `STAGE_TAPS; i++) begin
      sum += int'(cur_frame[i]) * int'(model_taps[i]);
    end
    return acc_t'(sum);
  endfunction

  // Each tap moves by error times sample shifted right and the bias by the shifted error
  function automatic void model_update(input err_t e, input logic taps_on, input logic bias_on);
    longint g;
    for (int i = 0; i < `STAGE_TAPS; i++) begin
      g = longint'(e) * longint'(cur_frame[i]);
      if (taps_on) begin
        model_taps[i] = weight_t'(longint'(model_taps[i]) + (g >>> `STAGE_MU_SHIFT));
      end
    end
    if (bias_on) begin
      model_bias = weight_t'(longint'(model_bias) + (longint'(e) >>> `STAGE_MU_SHIFT));
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drivers and checks
  //////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string what, input acc_t got, input acc_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic write_coef(input int idx, input weight_t value);
    coef_wr_en   = 1'b1;
    coef_wr_addr = `STAGE_IDX_W'(idx);
    coef_wr_data = value;
    step_cycle();
    coef_wr_en = 1'b0;
    if (idx == `STAGE_TAPS) begin
      model_bias = value;
    end else begin
      model_taps[idx] = value;
    end
  endtask

  task automatic send_frame();
    for (int i = 0; i < `STAGE_TAPS; i++) begin
      x_data = cur_frame[i];
      x_fst  = (i == 0);
      x_vld  = 1'b1;
      while (!x_rdy) begin
        step_cycle();
      end
      step_cycle();
    end
    x_vld = 1'b0;
    x_fst = 1'b0;
    check_flag("load_finish after last beat", load_finish, 1'b1);
    check_flag("x_rdy with frame buffered", x_rdy, 1'b0);
  endtask

  task automatic send_error(input err_t e);
    e_data = e;
    e_fst  = 1'b1;
    e_vld  = 1'b1;
    while (!e_rdy) begin
      step_cycle();
    end
    step_cycle();
    e_vld = 1'b0;
    e_fst = 1'b0;
  endtask

  // Waits for y_vld and may hold y_rdy low while a sample is offered
  task automatic take_output(input acc_t expected, input int hold_cycles);
    while (!y_vld) begin
      step_cycle();
    end
    check_value("y_data", y_data, expected);
    for (int i = 0; i < hold_cycles; i++) begin
      x_data = sample_t'($random(seed));
      x_vld  = 1'b1;
      step_cycle();
      check_flag("y_vld under back-pressure", y_vld, 1'b1);
      check_value("y_data under back-pressure", y_data, expected);
      check_flag("x_rdy under back-pressure", x_rdy, 1'b0);
    end
    x_vld = 1'b0;
    y_rdy = 1'b1;
    step_cycle();
    y_rdy = 1'b0;
  endtask

  task automatic run_frame(input logic taps_on, input logic bias_on, input err_t e);
    tap_update_enable  = taps_on;
    bias_update_enable = bias_on;
    send_frame();
    take_output(model_output(), 0);
    if (taps_on || bias_on) begin
      send_error(e);
      while (!update_done) begin
        step_cycle();
      end
      model_update(e, taps_on, bias_on);
      check_flag("x_rdy after update", x_rdy, 1'b1);
      check_flag("e_rdy after update", e_rdy, 1'b1);
      step_cycle();
      check_flag("update_done one cycle wide", update_done, 1'b0);
    end
    tap_update_enable  = 1'b0;
    bias_update_enable = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_flag("x_rdy after reset", x_rdy, 1'b1);
    check_flag("e_rdy after reset", e_rdy, 1'b1);
    check_flag("y_vld after reset", y_vld, 1'b0);
    check_flag("load_finish after reset", load_finish, 1'b0);
    check_flag("update_done after reset", update_done, 1'b0);
  endtask

  task automatic test_forward();
    int loads;
    int dones;
    loads = load_cnt;
    dones = done_cnt;
    write_coef(0, 16'sd3);
    write_coef(1, -16'sd2);
    write_coef(2, 16'sd5);
    write_coef(3, 16'sd7);
    write_coef(4, 16'sd100);
    cur_frame = '{16'sd10, 16'sd20, -16'sd30, 16'sd40};
    run_frame(1'b0, 1'b0, '0);
    check_value("load_finish pulses per frame", load_cnt - loads, 1);
    check_value("update_done pulses with enables off", done_cnt - dones, 0);
    check_flag("x_rdy after release", x_rdy, 1'b1);
    cur_frame = '{-16'sd1, 16'sd2, -16'sd3, 16'sd4};
    run_frame(1'b0, 1'b0, '0);
  endtask

  task automatic test_backpressure();
    cur_frame = '{16'sd1000, -16'sd7, 16'sd12, -16'sd33};
    send_frame();
    take_output(model_output(), 6);
    check_flag("x_rdy after back-pressure", x_rdy, 1'b1);
  endtask

  task automatic test_full_update();
    int dones;
    dones = done_cnt;
    cur_frame = '{16'sd300, -16'sd120, 16'sd45, 16'sd900};
    run_frame(1'b1, 1'b1, -24'sd3000);
    check_value("update_done pulses per update", done_cnt - dones, 1);
    // Same frame through the new coefficients
    run_frame(1'b0, 1'b0, '0);
  endtask

  task automatic test_tap_only();
    weight_t bias_before;
    bias_before = model_bias;
    cur_frame = '{16'sd17, 16'sd64, -16'sd250, 16'sd8};
    run_frame(1'b1, 1'b0, 24'sd90000);
    // All-zero frame exposes the bias alone
    cur_frame = '{default: '0};
    send_frame();
    take_output(acc_t'(bias_before), 0);
  endtask

  task automatic test_random();
    for (int n = 0; n < 20; n++) begin
      for (int i = 0; i < `STAGE_TAPS; i++) begin
        cur_frame[i] = sample_t'($random(seed));
      end
      run_frame(1'b1, 1'b1, err_t'($random(seed)));
    end
  endtask

  initial begin
    seed               = 31552;
    rst_n              = 1'b0;
    x_data             = '0;
    x_fst              = 1'b0;
    x_vld              = 1'b0;
    e_data             = '0;
    e_fst              = 1'b0;
    e_vld              = 1'b0;
    y_rdy              = 1'b0;
    tap_update_enable  = 1'b0;
    bias_update_enable = 1'b0;
    coef_wr_en         = 1'b0;
    coef_wr_addr       = '0;
    coef_wr_data       = '0;
    model_taps         = '{default: '0};
    model_bias         = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_forward();
    test_backpressure();
    test_full_update();
    test_tap_only();
    test_random();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+hdl
hdl/stage_pkg.sv
hdl/sample_stream_if.sv
hdl/coef_bus_if.sv
hdl/frame_buffer.sv
hdl/coef_store.sv
hdl/stage_seq.sv
hdl/stage_ctrl.sv
dv/stage_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stage_ctrl testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module stage_ctrl_tb -Mdir "$OBJ" -o stage_ctrl_tb_sim -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$OBJ/stage_ctrl_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi
exit 0
